// File: hdl/desc_scheduler.sv
`timescale 1ns/1ps

module desc_scheduler (
  input  logic                                             clk,
  input  logic                                             rst_r,
  input  logic [sched_pkg::IF_COUNT-1:0]                   hash_valid,
  input  sched_pkg::hash_t [sched_pkg::IF_COUNT-1:0]       hash_data,
  output logic [sched_pkg::IF_COUNT-1:0]                   hash_ready,
  input  sched_pkg::line_count_t [sched_pkg::IF_COUNT-1:0] line_count,
  output logic [sched_pkg::IF_COUNT-1:0]                   desc_valid,
  input  logic [sched_pkg::IF_COUNT-1:0]                   desc_ready,
  output logic [sched_pkg::IF_COUNT-1:0]                   desc_drop,
  output sched_pkg::hash_t [sched_pkg::IF_COUNT-1:0]       desc_hash,
  output sched_pkg::core_id_t [sched_pkg::IF_COUNT-1:0]    desc_core,
  output sched_pkg::slot_t [sched_pkg::IF_COUNT-1:0]       desc_slot,
  input  logic                                             ctrl_valid,
  input  sched_pkg::ctrl_t                                 ctrl_data,
  input  sched_pkg::core_id_t                              ctrl_core,
  input  sched_pkg::word_t                                 host_cmd,
  input  sched_pkg::word_t                                 host_wr_data,
  input  logic                                             host_valid,
  output sched_pkg::word_t                                 host_rd_data
);

  import sched_pkg::*;

  logic [IF_COUNT-1:0]          q_valid;
  hash_t [IF_COUNT-1:0]         q_hash;
  logic [IF_COUNT-1:0]          q_ready;
  logic [IF_COUNT-1:0]          push_valid;
  logic [IF_COUNT-1:0]          push_ready;
  logic [IF_COUNT-1:0]          push_drop;
  hash_t [IF_COUNT-1:0]         push_hash;
  core_id_t [IF_COUNT-1:0]      push_core;
  slot_t [IF_COUNT-1:0]         push_slot;
  slot_t [CORE_COUNT-1:0]       slot_head;
  slot_t [CORE_COUNT-1:0]       slot_count;
  core_mask_t                   slot_valid;
  core_mask_t                   slot_pop;
  core_mask_t                   slot_flush;
  core_mask_t                   income_cores;
  logic [IF_COUNT-1:0]          almost_full;
  word_t [IF_COUNT-1:0]         drop_count;

  for (genvar i = 0; i < IF_COUNT; i++) begin : g_if
    flow_fifo #(.WIDTH($bits(hash_t)), .DEPTH(HASH_FIFO_DEPTH)) u_hash_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (hash_valid[i]),
      .in_data   (hash_data[i]),
      .in_ready  (hash_ready[i]),
      .out_valid (q_valid[i]),
      .out_data  (q_hash[i]),
      .out_ready (q_ready[i])
    );

    flow_fifo #(.WIDTH(DESC_WIDTH), .DEPTH(DESC_FIFO_DEPTH)) u_desc_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (push_valid[i]),
      .in_data   ({push_drop[i], push_hash[i], push_core[i], push_slot[i]}),
      .in_ready  (push_ready[i]),
      .out_valid (desc_valid[i]),
      .out_data  ({desc_drop[i], desc_hash[i], desc_core[i], desc_slot[i]}),
      .out_ready (desc_ready[i])
    );
  end

  slot_bank u_slot_bank (
    .clk        (clk),
    .rst_r      (rst_r),
    .ctrl_valid (ctrl_valid),
    .ctrl_data  (ctrl_data),
    .ctrl_core  (ctrl_core),
    .slot_flush (slot_flush),
    .slot_pop   (slot_pop),
    .slot_head  (slot_head),
    .slot_valid (slot_valid),
    .slot_count (slot_count),
    .slot_err   ()
  );

  rx_allocator u_rx_allocator (
    .clk          (clk),
    .rst_r        (rst_r),
    .q_valid      (q_valid),
    .q_hash       (q_hash),
    .q_ready      (q_ready),
    .push_ready   (push_ready),
    .push_valid   (push_valid),
    .push_drop    (push_drop),
    .push_hash    (push_hash),
    .push_core    (push_core),
    .push_slot    (push_slot),
    .slot_head    (slot_head),
    .slot_valid   (slot_valid),
    .slot_pop     (slot_pop),
    .income_cores (income_cores),
    .almost_full  (almost_full),
    .drop_count   (drop_count)
  );

  host_regs u_host_regs (
    .clk           (clk),
    .rst_r         (rst_r),
    .host_cmd      (host_cmd),
    .host_wr_data  (host_wr_data),
    .host_valid    (host_valid),
    .host_rd_data  (host_rd_data),
    .line_count    (line_count),
    .slot_count    (slot_count),
    .drop_count    (drop_count),
    .enabled_cores (),
    .income_cores  (income_cores),
    .slot_flush    (slot_flush),
    .almost_full   (almost_full)
  );

endmodule

// File: hdl/flow_fifo.sv
`timescale 1ns/1ps

module flow_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             in_ready,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data,
  input  logic             out_ready
);

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       push;
  logic                       pop;

  assign in_ready  = count != DEPTH;
  assign out_valid = count != 0;
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  // Pointers wrap on their own, DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // A write into a full queue would land on the stalled head entry
  a_no_push_full: assert property (@(posedge clk) disable iff (rst_r)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("flow_fifo head entry overwritten while stalled");

  // A read from an empty queue would wrap the fill count
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_r)
    count <= DEPTH)
    else $error("flow_fifo fill count out of range");

endmodule

// File: hdl/host_regs.sv
`timescale 1ns/1ps

module host_regs (
  input  logic                                             clk,
  input  logic                                             rst_r,
  input  sched_pkg::word_t                                 host_cmd,
  input  sched_pkg::word_t                                 host_wr_data,
  input  logic                                             host_valid,
  output sched_pkg::word_t                                 host_rd_data,
  input  sched_pkg::line_count_t [sched_pkg::IF_COUNT-1:0] line_count,
  input  sched_pkg::slot_t [sched_pkg::CORE_COUNT-1:0]     slot_count,
  input  sched_pkg::word_t [sched_pkg::IF_COUNT-1:0]       drop_count,
  output sched_pkg::core_mask_t                            enabled_cores,
  output sched_pkg::core_mask_t                            income_cores,
  output sched_pkg::core_mask_t                            slot_flush,
  output logic [sched_pkg::IF_COUNT-1:0]                   almost_full
);

  import sched_pkg::*;

  word_t       cmd_r;
  word_t       wr_data_r;
  word_t       rd_data_n;
  logic        wr_r;
  logic [4:0]  reg_sel;
  core_id_t    rd_core;
  if_id_t      rd_if;
  line_count_t drop_limit;

  // Bit 30 picks the interface registers, bits 3 to 0 the register
  assign reg_sel = {cmd_r[30], cmd_r[3:0]};
  assign rd_core = core_id_t'(cmd_r[7:4]);
  assign rd_if   = if_id_t'(cmd_r[7:4]);

  always_ff @(posedge clk) begin
    cmd_r     <= host_cmd;
    wr_data_r <= host_wr_data;
    if (rst_r) begin
      wr_r          <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      slot_flush    <= '0;
      almost_full   <= '0;
      drop_limit    <= line_count_t'(DEFAULT_DROP_LIMIT);
    end else begin
      wr_r       <= host_valid && host_cmd[31] && host_cmd[29];
      slot_flush <= '0;
      if (wr_r) begin
        case (reg_sel)
          REG_CORE_ENABLE: begin
            // A disabled core may not keep taking packets
            enabled_cores <= core_mask_t'(wr_data_r);
            income_cores  <= income_cores & core_mask_t'(wr_data_r);
          end
          REG_CORE_INCOME: income_cores <= core_mask_t'(wr_data_r) & enabled_cores;
          REG_SLOT_FLUSH:  slot_flush   <= core_mask_t'(wr_data_r);
          REG_DROP_LIMIT:  drop_limit   <= line_count_t'(wr_data_r);
          default: ;
        endcase
      end
      for (int i = 0; i < IF_COUNT; i++)
        almost_full[i] <= line_count[i] >= drop_limit;
    end
  end

  // Two stages from the registered command to host_rd_data
  always_ff @(posedge clk) begin
    host_rd_data <= rd_data_n;
    case (reg_sel)
      REG_CORE_ENABLE: rd_data_n <= word_t'(enabled_cores);
      REG_CORE_INCOME: rd_data_n <= word_t'(income_cores);
      REG_SLOT_COUNT:  rd_data_n <= word_t'(slot_count[rd_core]);
      REG_DROP_COUNT:  rd_data_n <= rd_if < IF_COUNT ? drop_count[rd_if] : RD_UNMAPPED;
      default:         rd_data_n <= RD_UNMAPPED;
    endcase
  end

endmodule

// File: hdl/rx_allocator.sv
`timescale 1ns/1ps

module rx_allocator (
  input  logic                                         clk,
  input  logic                                         rst_r,
  input  logic [sched_pkg::IF_COUNT-1:0]               q_valid,
  input  sched_pkg::hash_t [sched_pkg::IF_COUNT-1:0]   q_hash,
  output logic [sched_pkg::IF_COUNT-1:0]               q_ready,
  input  logic [sched_pkg::IF_COUNT-1:0]               push_ready,
  output logic [sched_pkg::IF_COUNT-1:0]               push_valid,
  output logic [sched_pkg::IF_COUNT-1:0]               push_drop,
  output sched_pkg::hash_t [sched_pkg::IF_COUNT-1:0]   push_hash,
  output sched_pkg::core_id_t [sched_pkg::IF_COUNT-1:0] push_core,
  output sched_pkg::slot_t [sched_pkg::IF_COUNT-1:0]   push_slot,
  input  sched_pkg::slot_t [sched_pkg::CORE_COUNT-1:0] slot_head,
  input  sched_pkg::core_mask_t                        slot_valid,
  output sched_pkg::core_mask_t                        slot_pop,
  input  sched_pkg::core_mask_t                        income_cores,
  input  logic [sched_pkg::IF_COUNT-1:0]               almost_full,
  output sched_pkg::word_t [sched_pkg::IF_COUNT-1:0]   drop_count
);

  import sched_pkg::*;

  logic [IF_COUNT-1:0] req;
  logic [IF_COUNT-1:0] grant;
  logic [IF_COUNT-1:0] grant_r;
  logic [IF_COUNT-1:0] if_avail;
  if_id_t              last_if;
  if_id_t              grant_if;
  if_id_t              sel_if_r;
  logic                alloc;
  logic                drop;

  // Every interface presents a descriptor built from its own head hash
  for (genvar i = 0; i < IF_COUNT; i++) begin : g_if
    assign push_hash[i] = q_hash[i];
    assign push_core[i] = q_hash[i][HASH_SEL_OFFSET +: $bits(core_id_t)];
    assign if_avail[i]  = income_cores[push_core[i]] && slot_valid[push_core[i]];
    assign push_drop[i] = !if_avail[i];
    assign push_slot[i] = if_avail[i] ? slot_head[push_core[i]] : '0;
  end

  // The interface granted last cycle sits out while its decision is taken
  assign req = q_valid & push_ready & ~grant_r;

  // Round robin, searching from the interface after the last grant
  always_comb begin
    int idx;
    grant    = '0;
    grant_if = last_if;
    for (int k = 1; k <= IF_COUNT; k++) begin
      idx = int'(last_if) + k;
      if (idx >= IF_COUNT)
        idx = idx - IF_COUNT;
      if (grant == '0 && req[idx]) begin
        grant[idx] = 1'b1;
        grant_if   = if_id_t'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_r    <= '0;
      sel_if_r   <= '0;
      last_if    <= if_id_t'(IF_COUNT - 1);
      drop_count <= '0;
    end else begin
      grant_r  <= grant;
      sel_if_r <= grant_if;
      if (|grant)
        last_if <= grant_if;
      if (drop)
        drop_count[sel_if_r] <= drop_count[sel_if_r] + 1'b1;
    end
  end

  // Neither allocate nor drop means the hash waits and asks again
  assign alloc      = |grant_r && if_avail[sel_if_r];
  assign drop       = |grant_r && !if_avail[sel_if_r] && almost_full[sel_if_r];
  assign q_ready    = (alloc || drop) ? grant_r : '0;
  assign push_valid = q_ready;
  assign slot_pop   = alloc ? core_mask_t'(1) << push_core[sel_if_r] : '0;

  // The granted interface keeps its head hash and its descriptor room
  a_grant_held: assert property (@(posedge clk) disable iff (rst_r)
    (grant_r != '0) |-> q_valid[sel_if_r] && push_ready[sel_if_r])
    else $error("rx_allocator decided for an interface with no hash or no room");

endmodule

// File: hdl/sched_pkg.sv
package sched_pkg;

  localparam int IF_COUNT        = 3;
  localparam int CORE_COUNT      = 8;
  localparam int SLOT_COUNT      = 16;
  localparam int HASH_SEL_OFFSET = 14;
  localparam int HASH_FIFO_DEPTH = 8;
  localparam int DESC_FIFO_DEPTH = 8;

  localparam int DEFAULT_DROP_LIMIT = 3584;

  // Control message types handled here
  localparam logic [3:0] MSG_ENQ_SLOT   = 4'd0;
  localparam logic [3:0] MSG_INIT_SLOTS = 4'd3;

  // Host registers, coded as {interface select, register}
  localparam logic [4:0] REG_CORE_ENABLE = 5'h00;
  localparam logic [4:0] REG_CORE_INCOME = 5'h01;
  localparam logic [4:0] REG_SLOT_FLUSH  = 5'h02;
  localparam logic [4:0] REG_SLOT_COUNT  = 5'h03;
  localparam logic [4:0] REG_DROP_COUNT  = 5'h12;
  localparam logic [4:0] REG_DROP_LIMIT  = 5'h13;

  localparam logic [31:0] RD_UNMAPPED = 32'hFEFEFEFE;

  typedef logic [2:0]  core_id_t;
  typedef logic [1:0]  if_id_t;
  typedef logic [4:0]  slot_t;
  typedef logic [7:0]  core_mask_t;
  typedef logic [31:0] hash_t;
  typedef logic [35:0] ctrl_t;
  typedef logic [12:0] line_count_t;
  typedef logic [31:0] word_t;

  typedef enum logic {POOL_IDLE, POOL_FILL} pool_state_t;

  // Descriptor as stored in the output queues: {drop, hash, core, slot}
  localparam int DESC_WIDTH = 1 + $bits(hash_t) + $bits(core_id_t) + $bits(slot_t);

endpackage

// File: hdl/slot_bank.sv
`timescale 1ns/1ps

module slot_bank (
  input  logic                                         clk,
  input  logic                                         rst_r,
  input  logic                                         ctrl_valid,
  input  sched_pkg::ctrl_t                             ctrl_data,
  input  sched_pkg::core_id_t                          ctrl_core,
  input  sched_pkg::core_mask_t                        slot_flush,
  input  sched_pkg::core_mask_t                        slot_pop,
  output sched_pkg::slot_t [sched_pkg::CORE_COUNT-1:0] slot_head,
  output sched_pkg::core_mask_t                        slot_valid,
  output sched_pkg::slot_t [sched_pkg::CORE_COUNT-1:0] slot_count,
  output logic                                         slot_err
);

  import sched_pkg::*;

  logic [3:0] msg_type;
  core_mask_t enq_v;
  core_mask_t init_v;
  core_mask_t pool_err;
  slot_t      slot_in_r;

  // Type in the top nibble, slot number in bits 20 to 16
  assign msg_type = ctrl_data[35:32];

  always_ff @(posedge clk) begin
    slot_in_r <= ctrl_data[20:16];
    if (rst_r) begin
      enq_v    <= '0;
      init_v   <= '0;
      slot_err <= 1'b0;
    end else begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        enq_v[c]  <= ctrl_valid && msg_type == MSG_ENQ_SLOT && ctrl_core == core_id_t'(c);
        init_v[c] <= ctrl_valid && msg_type == MSG_INIT_SLOTS && ctrl_core == core_id_t'(c);
      end
      slot_err <= |pool_err;
    end
  end

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_pool
    slot_pool u_pool (
      .clk        (clk),
      .rst_r      (rst_r),
      .flush      (slot_flush[c]),
      .init_valid (init_v[c]),
      .enq_valid  (enq_v[c]),
      .slot_in    (slot_in_r),
      .pop        (slot_pop[c]),
      .slot_head  (slot_head[c]),
      .slot_valid (slot_valid[c]),
      .slot_count (slot_count[c]),
      .enq_err    (pool_err[c])
    );
  end

endmodule

// File: hdl/slot_pool.sv
`timescale 1ns/1ps

module slot_pool (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             flush,
  input  logic             init_valid,
  input  logic             enq_valid,
  input  sched_pkg::slot_t slot_in,
  input  logic             pop,
  output sched_pkg::slot_t slot_head,
  output logic             slot_valid,
  output sched_pkg::slot_t slot_count,
  output logic             enq_err
);

  import sched_pkg::*;

  slot_t                         mem [SLOT_COUNT];
  logic [$clog2(SLOT_COUNT)-1:0] wr_ptr;
  logic [$clog2(SLOT_COUNT)-1:0] rd_ptr;
  pool_state_t                   state;
  slot_t                         fill_next;
  slot_t                         fill_last;
  logic                          full;
  logic                          do_fill;
  logic                          do_enq;
  logic                          do_pop;

  assign full       = slot_count == slot_t'(SLOT_COUNT);
  assign slot_valid = state == POOL_IDLE && slot_count != 0;
  assign slot_head  = mem[rd_ptr];
  assign do_fill    = state == POOL_FILL && fill_next <= fill_last && !full;
  assign do_pop     = pop && slot_valid;

  // A slot returned while the pool is refilling is rejected as well
  assign do_enq = enq_valid && state == POOL_IDLE && !full &&
                  slot_in != 0 && slot_in <= SLOT_COUNT;

  always_ff @(posedge clk) begin
    if (do_fill || do_enq)
      mem[wr_ptr] <= do_fill ? fill_next : slot_in;
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      state      <= POOL_IDLE;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      slot_count <= '0;
      fill_next  <= '0;
      fill_last  <= '0;
      enq_err    <= 1'b0;
    end else begin
      enq_err <= enq_valid && !do_enq;
      if (init_valid) begin
        // Empty the pool, then write slots 1 to n one per cycle
        state      <= POOL_FILL;
        wr_ptr     <= '0;
        rd_ptr     <= '0;
        slot_count <= '0;
        fill_next  <= slot_t'(1);
        fill_last  <= slot_in;
      end else begin
        if (state == POOL_FILL && !do_fill)
          state <= POOL_IDLE;
        if (do_fill)
          fill_next <= fill_next + 1'b1;
        if (do_fill || do_enq)
          wr_ptr <= wr_ptr + 1'b1;
        if (do_pop)
          rd_ptr <= rd_ptr + 1'b1;
        if ((do_fill || do_enq) && !do_pop)
          slot_count <= slot_count + 1'b1;
        else if (do_pop && !(do_fill || do_enq))
          slot_count <= slot_count - 1'b1;
      end
    end
  end

  a_pop_valid: assert property (@(posedge clk) disable iff (rst_r || flush)
    pop |-> slot_valid)
    else $error("slot_pool popped without a free slot");

endmodule

// File: list.f
hdl/sched_pkg.sv
hdl/flow_fifo.sv
hdl/slot_pool.sv
hdl/slot_bank.sv
hdl/rx_allocator.sv
hdl/host_regs.sv
hdl/desc_scheduler.sv
tb/tb_clock.sv
tb/desc_scheduler_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module desc_scheduler_tb -o sim_desc_scheduler
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_desc_scheduler 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// File: tb/desc_scheduler_tb.sv
`timescale 1ns/1ps

module desc_scheduler_tb;

  import sched_pkg::*;

  // 24 + 2 + 4 + 2 + 300 hashes over all tests
  localparam int HASHES_SENT = 332;

  logic                            clk;
  logic                            rst_r;
  logic [IF_COUNT-1:0]             hash_valid;
  hash_t [IF_COUNT-1:0]            hash_data;
  logic [IF_COUNT-1:0]             hash_ready;
  line_count_t [IF_COUNT-1:0]      line_count;
  logic [IF_COUNT-1:0]             desc_valid;
  logic [IF_COUNT-1:0]             desc_ready;
  logic [IF_COUNT-1:0]             desc_drop;
  hash_t [IF_COUNT-1:0]            desc_hash;
  core_id_t [IF_COUNT-1:0]         desc_core;
  slot_t [IF_COUNT-1:0]            desc_slot;
  logic                            ctrl_valid;
  ctrl_t                           ctrl_data;
  core_id_t                        ctrl_core;
  word_t                           host_cmd;
  word_t                           host_wr_data;
  logic                            host_valid;
  word_t                           host_rd_data;

  // Reference model state
  core_mask_t  enabled_m;
  core_mask_t  income_m;
  logic        af_m;
  slot_t       slot_q [CORE_COUNT][$];
  hash_t       sent_q [IF_COUNT][$];
  hash_t       plan_q [IF_COUNT][$];
  word_t       drop_m [IF_COUNT];
  logic [38:0] ctrl_q [$];

  logic [31:0] lfsr = 32'h6908;
  logic        bp_on;
  logic        recycle;
  int          n_checks;
  int          n_errors;

  tb_clock u_clock (.clk(clk));

  desc_scheduler u_dut (
    .clk          (clk),
    .rst_r        (rst_r),
    .hash_valid   (hash_valid),
    .hash_data    (hash_data),
    .hash_ready   (hash_ready),
    .line_count   (line_count),
    .desc_valid   (desc_valid),
    .desc_ready   (desc_ready),
    .desc_drop    (desc_drop),
    .desc_hash    (desc_hash),
    .desc_core    (desc_core),
    .desc_slot    (desc_slot),
    .ctrl_valid   (ctrl_valid),
    .ctrl_data    (ctrl_data),
    .ctrl_core    (ctrl_core),
    .host_cmd     (host_cmd),
    .host_wr_data (host_wr_data),
    .host_valid   (host_valid),
    .host_rd_data (host_rd_data)
  );

  // Galois LFSR, one step per bit
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] bits;
    bits = '0;
    for (int b = 0; b < nbits; b++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hA3000000 : lfsr >> 1;
    end
    return bits;
  endfunction

  function automatic hash_t hash_for_core(input int core);
    hash_t h;
    h = lfsr_take(32);
    h[16:14] = core_id_t'(core);
    return h;
  endfunction

  function automatic word_t host_command(input logic wr, input logic [4:0] reg_code,
                                         input int idx);
    return {wr, reg_code[4], 1'b1, 21'd0, 4'(idx), reg_code[3:0]};
  endfunction

  // Queues a core message and applies it to the model
  function automatic void post_ctrl(input logic [3:0] kind, input core_id_t core,
                                    input slot_t slot);
    ctrl_q.push_back({core, kind, 11'd0, slot, 16'd0});
    if (kind == MSG_INIT_SLOTS) begin
      slot_q[core].delete();
      for (int s = 1; s <= int'(slot); s++)
        slot_q[core].push_back(slot_t'(s));
    end else begin
      slot_q[core].push_back(slot);
    end
  endfunction

  // Expected {sent, drop, core, slot}; sent low means the hash should wait
  function automatic logic [9:0] ref_desc(input int i, input hash_t h, input slot_t seen);
    core_id_t core;
    int       idx;
    slot_t    slot;
    core = h[16:14];
    if (income_m[core] && slot_q[core].size() > 0) begin
      idx = 0;
      if (bp_on) begin
        for (int j = 0; j < slot_q[core].size(); j++)
          if (slot_q[core][j] == seen)
            idx = j;
      end
      slot = slot_q[core][idx];
      slot_q[core].delete(idx);
      return {1'b1, 1'b0, core, slot};
    end
    if (af_m) begin
      drop_m[i] = drop_m[i] + 1;
      return {1'b1, 1'b1, core, 5'd0};
    end
    return {1'b0, 1'b0, core, 5'd0};
  endfunction

  task automatic send_hash(input int i, input hash_t h);
    @(negedge clk);
    hash_valid[i] = 1'b1;
    hash_data[i]  = h;
    while (!hash_ready[i])
      @(negedge clk);
    sent_q[i].push_back(h);
    @(negedge clk);
    hash_valid[i] = 1'b0;
  endtask

  task automatic send_stream(input int i);
    while (plan_q[i].size() > 0)
      send_hash(i, plan_q[i].pop_front());
  endtask

  task automatic wait_drained();
    while (sent_q[0].size() + sent_q[1].size() + sent_q[2].size() != 0)
      @(negedge clk);
  endtask

  // Lets queued messages reach the pools and any fill complete
  task automatic wait_settled();
    while (ctrl_q.size() != 0)
      @(negedge clk);
    repeat (SLOT_COUNT + 4) @(negedge clk);
  endtask

  // Drives a register write and applies its rule to the model
  task automatic host_write(input logic [4:0] reg_code, input int idx, input word_t data);
    @(negedge clk);
    host_cmd     = host_command(1'b1, reg_code, idx);
    host_wr_data = data;
    host_valid   = 1'b1;
    @(negedge clk);
    host_valid = 1'b0;
    repeat (2) @(negedge clk);
    case (reg_code)
      REG_CORE_ENABLE: begin
        enabled_m = core_mask_t'(data);
        income_m  = income_m & core_mask_t'(data);
      end
      REG_CORE_INCOME: income_m = core_mask_t'(data) & enabled_m;
      REG_SLOT_FLUSH: begin
        for (int c = 0; c < CORE_COUNT; c++)
          if (data[c])
            slot_q[c].delete();
      end
      default: ;
    endcase
  endtask

  task automatic check_read(input string what, input logic [4:0] reg_code, input int idx,
                            input word_t exp);
    word_t got;
    @(negedge clk);
    host_cmd = host_command(1'b0, reg_code, idx);
    repeat (5) @(negedge clk);
    got = host_rd_data;
    n_checks++;
    if (got !== exp) begin
      $display("error host_rd_data %s got %h exp %h", what, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_slot_counts();
    for (int c = 0; c < CORE_COUNT; c++)
      check_read($sformatf("slot count core %0d", c), REG_SLOT_COUNT, c,
                 word_t'(slot_q[c].size()));
  endtask

  task automatic check_drop_counts();
    for (int i = 0; i < IF_COUNT; i++)
      check_read($sformatf("drop count if %0d", i), REG_DROP_COUNT, i, drop_m[i]);
  endtask

  task automatic end_test(input string name, input int mark);
    $display("test %s: %s", name, n_errors == mark ? "ok" : "errors found");
  endtask

  // Core side of the control port, one message per cycle
  always @(negedge clk) begin
    if (ctrl_q.size() > 0) begin
      {ctrl_core, ctrl_data} = ctrl_q.pop_front();
      ctrl_valid = 1'b1;
    end else begin
      ctrl_valid = 1'b0;
    end
  end

  always @(negedge clk) begin
    logic [31:0] bits;
    bits = bp_on ? lfsr_take(IF_COUNT) : '1;
    desc_ready = bits[IF_COUNT-1:0];
  end

  // Descriptor compare against the model
  always @(posedge clk) begin
    hash_t      h;
    logic [9:0] exp;
    if (!rst_r) begin
      for (int i = 0; i < IF_COUNT; i++) begin
        if (desc_valid[i] && desc_ready[i]) begin
          n_checks++;
          if (sent_q[i].size() == 0) begin
            $display("descriptor on interface %0d with no hash outstanding", i);
            n_errors++;
          end else begin
            h   = sent_q[i].pop_front();
            exp = ref_desc(i, h, desc_slot[i]);
            if (!exp[9]) begin
              $display("descriptor on interface %0d for a hash that should wait", i);
              n_errors++;
            end else begin
              if (desc_hash[i] != h) begin
                $display("error desc_hash[%0d] got %h exp %h", i, desc_hash[i], h);
                n_errors++;
              end
              if (desc_drop[i] != exp[8]) begin
                $display("error desc_drop[%0d] got %h exp %h", i, desc_drop[i], exp[8]);
                n_errors++;
              end
              if (desc_core[i] != exp[7:5]) begin
                $display("error desc_core[%0d] got %h exp %h", i, desc_core[i], exp[7:5]);
                n_errors++;
              end
              if (desc_slot[i] != exp[4:0]) begin
                $display("error desc_slot[%0d] got %h exp %h", i, desc_slot[i], exp[4:0]);
                n_errors++;
              end
            end
            if (recycle && !desc_drop[i])
              post_ctrl(MSG_ENQ_SLOT, desc_core[i], desc_slot[i]);
          end
        end
      end
    end
  end

  initial begin
    repeat (200 * HASHES_SENT + 2000) @(posedge clk);
    $display("timeout: the run did not complete in the allowed time");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int mark;
    rst_r        = 1'b1;
    hash_valid   = '0;
    hash_data    = '0;
    line_count   = '0;
    desc_ready   = '1;
    ctrl_valid   = 1'b0;
    ctrl_data    = '0;
    ctrl_core    = '0;
    host_cmd     = '0;
    host_wr_data = '0;
    host_valid   = 1'b0;
    enabled_m    = '0;
    income_m     = '0;
    af_m         = 1'b0;
    bp_on        = 1'b0;
    recycle      = 1'b0;
    n_checks     = 0;
    n_errors     = 0;
    for (int i = 0; i < IF_COUNT; i++)
      drop_m[i] = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;

    mark = n_errors;
    n_checks++;
    if (desc_valid !== '0) begin
      $display("error desc_valid got %h exp %h", desc_valid, 3'h0);
      n_errors++;
    end
    check_read("core enable", REG_CORE_ENABLE, 0, 32'h0);
    check_read("core income", REG_CORE_INCOME, 0, 32'h0);
    check_read("unmapped", 5'h05, 0, RD_UNMAPPED);
    check_read("drop count if 0", REG_DROP_COUNT, 0, 32'h0);
    end_test("1 reset", mark);

    mark = n_errors;
    host_write(REG_CORE_ENABLE, 0, 32'hFF);
    host_write(REG_CORE_INCOME, 0, 32'hFF);
    for (int c = 0; c < CORE_COUNT; c++)
      post_ctrl(MSG_INIT_SLOTS, core_id_t'(c), slot_t'(4));
    wait_settled();
    // Cores cycle so that each one gives away three of its four slots
    for (int k = 0; k < 8; k++)
      for (int i = 0; i < IF_COUNT; i++)
        plan_q[i].push_back(hash_for_core((k * IF_COUNT + i) % CORE_COUNT));
    fork
      send_stream(0);
      send_stream(1);
      send_stream(2);
    join
    wait_drained();
    check_slot_counts();
    end_test("2 allocation", mark);

    mark = n_errors;
    send_hash(0, hash_for_core(0));
    send_hash(0, hash_for_core(0));
    repeat (40) @(negedge clk);
    n_checks++;
    if (sent_q[0].size() != 1) begin
      $display("hash for an empty core did not wait for a slot");
      n_errors++;
    end
    post_ctrl(MSG_ENQ_SLOT, 3'd0, slot_t'(9));
    wait_drained();
    end_test("3 exhaustion below drop limit", mark);

    mark = n_errors;
    host_write(REG_DROP_LIMIT, 0, 32'd100);
    line_count = {IF_COUNT{line_count_t'(200)}};
    af_m       = 1'b1;
    repeat (3) @(negedge clk);
    for (int k = 0; k < 4; k++)
      send_hash(1, hash_for_core(1));
    wait_drained();
    check_drop_counts();
    end_test("4 drop limit", mark);

    mark = n_errors;
    host_write(REG_CORE_ENABLE, 0, 32'hFB);
    check_read("core income", REG_CORE_INCOME, 0, word_t'(income_m));
    for (int k = 0; k < 2; k++)
      send_hash(2, hash_for_core(2));
    wait_drained();
    host_write(REG_SLOT_FLUSH, 0, 32'h04);
    check_read("slot count core 2", REG_SLOT_COUNT, 2, 32'h0);
    check_drop_counts();
    end_test("5 masks and flush", mark);

    mark = n_errors;
    line_count = '0;
    af_m       = 1'b0;
    host_write(REG_CORE_ENABLE, 0, 32'hFF);
    host_write(REG_CORE_INCOME, 0, 32'hFF);
    for (int c = 0; c < CORE_COUNT; c++)
      post_ctrl(MSG_INIT_SLOTS, core_id_t'(c), slot_t'(4));
    wait_settled();
    for (int k = 0; k < 100; k++)
      for (int i = 0; i < IF_COUNT; i++)
        plan_q[i].push_back(hash_for_core(int'(lfsr_take(3))));
    recycle = 1'b1;
    bp_on   = 1'b1;
    fork
      send_stream(0);
      send_stream(1);
      send_stream(2);
    join
    wait_drained();
    bp_on   = 1'b0;
    recycle = 1'b0;
    wait_settled();
    check_slot_counts();
    end_test("6 back-pressure", mark);

    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule
